// File: verilog/soc_pkg.sv
`default_nettype none

package soc_pkg;

    localparam int unsigned DATA_WIDTH = 32;
    localparam int unsigned ADDR_WIDTH = 32;
    localparam int unsigned STRB_WIDTH = DATA_WIDTH / 8;

    localparam logic [ADDR_WIDTH-1:0] SRAM_BASE    = 32'h0002_0000;
    localparam logic [ADDR_WIDTH-1:0] SYSTICK_BASE = 32'h8000_0100;
    localparam logic [ADDR_WIDTH-1:0] SYSTICK_SIZE = 32'h0000_0010;
    localparam logic [ADDR_WIDTH-1:0] GPIO_BASE    = 32'h8000_0400;
    localparam logic [ADDR_WIDTH-1:0] GPIO_SIZE    = 32'h0000_0020;

    typedef enum logic [1:0] {
        SYSTICK_CTRL   = 2'd0,
        SYSTICK_LOAD   = 2'd1,
        SYSTICK_VALUE  = 2'd2,
        SYSTICK_STATUS = 2'd3
    } systick_reg_e;

    typedef enum logic [2:0] {
        GPIO_OUT      = 3'd0,
        GPIO_DIR      = 3'd1,
        GPIO_IN       = 3'd2,
        GPIO_IRQ_EN   = 3'd3,
        GPIO_IRQ_PEND = 3'd4
    } gpio_reg_e;

    // Unsigned wrap makes addresses below base look huge, so one compare covers both ends
    function automatic logic in_window(input logic [ADDR_WIDTH-1:0] addr,
                                       input logic [ADDR_WIDTH-1:0] base,
                                       input logic [ADDR_WIDTH-1:0] size);
        return (addr - base) < size;
    endfunction

    function automatic logic [DATA_WIDTH-1:0] strobe_mask(input logic [STRB_WIDTH-1:0] strb);
        logic [DATA_WIDTH-1:0] mask;
        for (int b = 0; b < STRB_WIDTH; b++) begin
            mask[8*b +: 8] = {8{strb[b]}};
        end
        return mask;
    endfunction

endpackage

`default_nettype wire

// File: verilog/sram.sv
`timescale 1ns/10ps
`default_nettype none

module sram #(
    parameter int unsigned ADDR_BITS = 13
) (
    input  logic                              clk_i,
    input  logic                              arst_n_i,
    input  logic                              sel_i,
    input  logic [ADDR_BITS-1:0]              addr_i,
    input  logic [soc_pkg::DATA_WIDTH-1:0]    wdata_i,
    input  logic [soc_pkg::STRB_WIDTH-1:0]    wstrb_i,
    output logic                              ready_o,
    output logic [soc_pkg::DATA_WIDTH-1:0]    rdata_o
);

    localparam int unsigned WORDS = 2 ** (ADDR_BITS - 2);

    logic [soc_pkg::DATA_WIDTH-1:0] mem_q [WORDS];
    logic [soc_pkg::DATA_WIDTH-1:0] rdata_q;
    logic [ADDR_BITS-3:0]           word_idx;
    logic                           ready_q;
    logic                           rd_en;
    logic                           wr_en;

    assign word_idx = addr_i[ADDR_BITS-1:2];
    assign rd_en    = sel_i & ~ready_q;    // Edge that raises ready
    assign wr_en    = sel_i & ready_q;     // Edge where the master samples ready

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= rd_en;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_en) begin
            rdata_q <= mem_q[word_idx];
        end
        if (wr_en) begin
            for (int b = 0; b < soc_pkg::STRB_WIDTH; b++) begin
                if (wstrb_i[b]) begin
                    mem_q[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    assign ready_o = ready_q;
    assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: verilog/systick.sv
`timescale 1ns/10ps
`default_nettype none

module systick (
    input  logic                              clk_i,
    input  logic                              arst_n_i,
    input  logic                              sel_i,
    input  logic [3:0]                        addr_i,
    input  logic [soc_pkg::DATA_WIDTH-1:0]    wdata_i,
    input  logic [soc_pkg::STRB_WIDTH-1:0]    wstrb_i,
    output logic                              ready_o,
    output logic [soc_pkg::DATA_WIDTH-1:0]    rdata_o,
    output logic                              irq_o
);

    soc_pkg::systick_reg_e          reg_sel;
    logic [soc_pkg::DATA_WIDTH-1:0] wmask;
    logic [soc_pkg::DATA_WIDTH-1:0] load_next;
    logic [soc_pkg::DATA_WIDTH-1:0] rd_next;
    logic [soc_pkg::DATA_WIDTH-1:0] rdata_q;
    logic [soc_pkg::DATA_WIDTH-1:0] load_q;
    logic [soc_pkg::DATA_WIDTH-1:0] value_q;
    logic [1:0]                     ctrl_q;
    logic                           status_q;
    logic                           ready_q;
    logic                           wr_en;
    logic                           wrap;

    assign reg_sel   = soc_pkg::systick_reg_e'(addr_i[3:2]);
    assign wmask     = soc_pkg::strobe_mask(wstrb_i);
    assign wr_en     = sel_i & ready_q & (|wstrb_i);
    assign load_next = (load_q & ~wmask) | (wdata_i & wmask);
    assign wrap      = ctrl_q[0] & (value_q == '0);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ready_q  <= 1'b0;
            ctrl_q   <= 2'b00;
            load_q   <= '0;
            value_q  <= '0;
            status_q <= 1'b0;
        end else begin
            ready_q <= sel_i & ~ready_q;
            if (wr_en && reg_sel == soc_pkg::SYSTICK_CTRL) begin
                ctrl_q <= (ctrl_q & ~wmask[1:0]) | (wdata_i[1:0] & wmask[1:0]);
            end
            if (wr_en && reg_sel == soc_pkg::SYSTICK_LOAD) begin
                load_q  <= load_next;
                value_q <= load_next;           // Restart the period right away
            end else if (wrap) begin
                value_q <= load_q;
            end else if (ctrl_q[0]) begin
                value_q <= value_q - 1'b1;
            end
            if (wrap) begin
                status_q <= 1'b1;               // A new wrap wins over a clear in the same cycle
            end else if (wr_en && reg_sel == soc_pkg::SYSTICK_STATUS && wmask[0] && wdata_i[0]) begin
                status_q <= 1'b0;
            end
        end
    end

    always_comb begin
        rd_next = '0;
        case (reg_sel)
            soc_pkg::SYSTICK_CTRL:   rd_next[1:0] = ctrl_q;
            soc_pkg::SYSTICK_LOAD:   rd_next      = load_q;
            soc_pkg::SYSTICK_VALUE:  rd_next      = value_q;
            soc_pkg::SYSTICK_STATUS: rd_next[0]   = status_q;
            default:                 rd_next      = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (sel_i && !ready_q) begin
            rdata_q <= rd_next;
        end
    end

    assign ready_o = ready_q;
    assign rdata_o = rdata_q;
    assign irq_o   = status_q & ctrl_q[1];

endmodule

`default_nettype wire

// File: verilog/gpio.sv
`timescale 1ns/10ps
`default_nettype none

module gpio #(
    parameter int unsigned WIDTH = 8
) (
    input  logic                              clk_i,
    input  logic                              arst_n_i,
    input  logic                              sel_i,
    input  logic [4:0]                        addr_i,
    input  logic [soc_pkg::DATA_WIDTH-1:0]    wdata_i,
    input  logic [soc_pkg::STRB_WIDTH-1:0]    wstrb_i,
    output logic                              ready_o,
    output logic [soc_pkg::DATA_WIDTH-1:0]    rdata_o,
    output logic                              irq_o,
    input  logic [WIDTH-1:0]                  pins_i,
    output logic [WIDTH-1:0]                  pins_o,
    output logic [WIDTH-1:0]                  pins_oe_o
);

    soc_pkg::gpio_reg_e             reg_sel;
    logic [soc_pkg::DATA_WIDTH-1:0] wmask_full;
    logic [soc_pkg::DATA_WIDTH-1:0] rd_next;
    logic [soc_pkg::DATA_WIDTH-1:0] rdata_q;
    logic [WIDTH-1:0]               wmask;
    logic [WIDTH-1:0]               wbits;
    logic [WIDTH-1:0]               sync1_q;
    logic [WIDTH-1:0]               sync2_q;
    logic [WIDTH-1:0]               in_q;
    logic [WIDTH-1:0]               out_q;
    logic [WIDTH-1:0]               dir_q;
    logic [WIDTH-1:0]               ie_q;
    logic [WIDTH-1:0]               pend_q;
    logic [WIDTH-1:0]               rise;
    logic                           ready_q;
    logic                           wr_en;

    assign reg_sel    = soc_pkg::gpio_reg_e'(addr_i[4:2]);
    assign wmask_full = soc_pkg::strobe_mask(wstrb_i);
    assign wmask      = wmask_full[WIDTH-1:0];
    assign wbits      = wdata_i[WIDTH-1:0] & wmask;
    assign wr_en      = sel_i & ready_q & (|wstrb_i);
    assign rise       = sync2_q & ~in_q & ie_q;     // in_q doubles as the previous sample

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ready_q <= 1'b0;
            sync1_q <= '0;
            sync2_q <= '0;
            in_q    <= '0;
            out_q   <= '0;
            dir_q   <= '0;
            ie_q    <= '0;
            pend_q  <= '0;
        end else begin
            ready_q <= sel_i & ~ready_q;
            sync1_q <= pins_i;
            sync2_q <= sync1_q;
            in_q    <= sync2_q;
            if (wr_en && reg_sel == soc_pkg::GPIO_OUT) begin
                out_q <= (out_q & ~wmask) | wbits;
            end
            if (wr_en && reg_sel == soc_pkg::GPIO_DIR) begin
                dir_q <= (dir_q & ~wmask) | wbits;
            end
            if (wr_en && reg_sel == soc_pkg::GPIO_IRQ_EN) begin
                ie_q <= (ie_q & ~wmask) | wbits;
            end
            if (wr_en && reg_sel == soc_pkg::GPIO_IRQ_PEND) begin
                pend_q <= (pend_q & ~wbits) | rise;  // Write 1 clears, a fresh edge still sets
            end else begin
                pend_q <= pend_q | rise;
            end
        end
    end

    always_comb begin
        rd_next = '0;
        case (reg_sel)
            soc_pkg::GPIO_OUT:      rd_next[WIDTH-1:0] = out_q;
            soc_pkg::GPIO_DIR:      rd_next[WIDTH-1:0] = dir_q;
            soc_pkg::GPIO_IN:       rd_next[WIDTH-1:0] = in_q;
            soc_pkg::GPIO_IRQ_EN:   rd_next[WIDTH-1:0] = ie_q;
            soc_pkg::GPIO_IRQ_PEND: rd_next[WIDTH-1:0] = pend_q;
            default:                rd_next            = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (sel_i && !ready_q) begin
            rdata_q <= rd_next;
        end
    end

    assign ready_o   = ready_q;
    assign rdata_o   = rdata_q;
    assign irq_o     = |pend_q;
    assign pins_o    = out_q;
    assign pins_oe_o = dir_q;

endmodule

`default_nettype wire

// File: verilog/bus_interconnect.sv
`timescale 1ns/10ps
`default_nettype none

module bus_interconnect #(
    parameter int unsigned SRAM_ADDR_WIDTH = 13
) (
    input  logic                              clk_i,
    input  logic                              arst_n_i,
    input  logic                              mem_valid_i,
    input  logic [soc_pkg::ADDR_WIDTH-1:0]    mem_addr_i,
    input  logic [soc_pkg::DATA_WIDTH-1:0]    mem_wdata_i,
    input  logic [soc_pkg::STRB_WIDTH-1:0]    mem_wstrb_i,
    output logic                              mem_ready_o,
    output logic [soc_pkg::DATA_WIDTH-1:0]    mem_rdata_o,
    output logic [soc_pkg::ADDR_WIDTH-1:0]    bus_addr_o,
    output logic [soc_pkg::DATA_WIDTH-1:0]    bus_wdata_o,
    output logic [soc_pkg::STRB_WIDTH-1:0]    bus_wstrb_o,
    output logic                              sram_sel_o,
    output logic                              systick_sel_o,
    output logic                              gpio_sel_o,
    input  logic                              sram_ready_i,
    input  logic                              systick_ready_i,
    input  logic                              gpio_ready_i,
    input  logic [soc_pkg::DATA_WIDTH-1:0]    sram_rdata_i,
    input  logic [soc_pkg::DATA_WIDTH-1:0]    systick_rdata_i,
    input  logic [soc_pkg::DATA_WIDTH-1:0]    gpio_rdata_i
);

    localparam logic [soc_pkg::ADDR_WIDTH-1:0] SRAM_SIZE = 1 << SRAM_ADDR_WIDTH;

    logic sram_hit;
    logic systick_hit;
    logic gpio_hit;
    logic unmapped_sel;
    logic unmapped_ready_q;

    // Memory map, windows never overlap so at most one hit is set
    assign sram_hit    = soc_pkg::in_window(mem_addr_i, soc_pkg::SRAM_BASE, SRAM_SIZE);
    assign systick_hit = soc_pkg::in_window(mem_addr_i, soc_pkg::SYSTICK_BASE,
                                            soc_pkg::SYSTICK_SIZE);
    assign gpio_hit    = soc_pkg::in_window(mem_addr_i, soc_pkg::GPIO_BASE,
                                            soc_pkg::GPIO_SIZE);

    assign sram_sel_o    = mem_valid_i & sram_hit;
    assign systick_sel_o = mem_valid_i & systick_hit;
    assign gpio_sel_o    = mem_valid_i & gpio_hit;
    assign unmapped_sel  = mem_valid_i & ~(sram_hit | systick_hit | gpio_hit);

    assign bus_addr_o  = mem_addr_i;
    assign bus_wdata_o = mem_wdata_i;
    assign bus_wstrb_o = mem_wstrb_i;

    // Answers holes in the map so the master never hangs
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            unmapped_ready_q <= 1'b0;
        end else begin
            unmapped_ready_q <= unmapped_sel & ~unmapped_ready_q; // One pulse per held access
        end
    end

    assign mem_ready_o = mem_valid_i &
                         (sram_ready_i | systick_ready_i | gpio_ready_i | unmapped_ready_q);

    always_comb begin
        if (sram_sel_o) begin
            mem_rdata_o = sram_rdata_i;
        end else if (systick_sel_o) begin
            mem_rdata_o = systick_rdata_i;
        end else if (gpio_sel_o) begin
            mem_rdata_o = gpio_rdata_i;
        end else begin
            mem_rdata_o = '0; // Unmapped reads return zero
        end
    end

endmodule

`default_nettype wire

// File: verilog/periph_subsys.sv
`timescale 1ns/10ps
`default_nettype none

module periph_subsys #(
    parameter int unsigned SRAM_ADDR_WIDTH = 13,
    parameter int unsigned GPIO_WIDTH      = 8
) (
    input  logic                              clk_i,
    input  logic                              arst_n_i,
    input  logic                              mem_valid_i,
    input  logic [soc_pkg::ADDR_WIDTH-1:0]    mem_addr_i,
    input  logic [soc_pkg::DATA_WIDTH-1:0]    mem_wdata_i,
    input  logic [soc_pkg::STRB_WIDTH-1:0]    mem_wstrb_i,
    output logic                              mem_ready_o,
    output logic [soc_pkg::DATA_WIDTH-1:0]    mem_rdata_o,
    output logic [1:0]                        irq_o,
    input  logic [GPIO_WIDTH-1:0]             gpio_i,
    output logic [GPIO_WIDTH-1:0]             gpio_o,
    output logic [GPIO_WIDTH-1:0]             gpio_oe_o
);

    logic [soc_pkg::ADDR_WIDTH-1:0] bus_addr;
    logic [soc_pkg::DATA_WIDTH-1:0] bus_wdata;
    logic [soc_pkg::STRB_WIDTH-1:0] bus_wstrb;
    logic                           sram_sel;
    logic                           sram_ready;
    logic [soc_pkg::DATA_WIDTH-1:0] sram_rdata;
    logic                           systick_sel;
    logic                           systick_ready;
    logic [soc_pkg::DATA_WIDTH-1:0] systick_rdata;
    logic                           gpio_sel;
    logic                           gpio_ready;
    logic [soc_pkg::DATA_WIDTH-1:0] gpio_rdata;

    bus_interconnect #(
        .SRAM_ADDR_WIDTH (SRAM_ADDR_WIDTH)
    ) i_bus_interconnect (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .mem_valid_i     (mem_valid_i),
        .mem_addr_i      (mem_addr_i),
        .mem_wdata_i     (mem_wdata_i),
        .mem_wstrb_i     (mem_wstrb_i),
        .mem_ready_o     (mem_ready_o),
        .mem_rdata_o     (mem_rdata_o),
        .bus_addr_o      (bus_addr),
        .bus_wdata_o     (bus_wdata),
        .bus_wstrb_o     (bus_wstrb),
        .sram_sel_o      (sram_sel),
        .systick_sel_o   (systick_sel),
        .gpio_sel_o      (gpio_sel),
        .sram_ready_i    (sram_ready),
        .systick_ready_i (systick_ready),
        .gpio_ready_i    (gpio_ready),
        .sram_rdata_i    (sram_rdata),
        .systick_rdata_i (systick_rdata),
        .gpio_rdata_i    (gpio_rdata)
    );

    // SRAM base is aligned to its window, so the low address bits are the offset
    sram #(
        .ADDR_BITS (SRAM_ADDR_WIDTH)
    ) i_sram (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .sel_i    (sram_sel),
        .addr_i   (bus_addr[SRAM_ADDR_WIDTH-1:0]),
        .wdata_i  (bus_wdata),
        .wstrb_i  (bus_wstrb),
        .ready_o  (sram_ready),
        .rdata_o  (sram_rdata)
    );

    systick i_systick (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .sel_i    (systick_sel),
        .addr_i   (bus_addr[3:0]),
        .wdata_i  (bus_wdata),
        .wstrb_i  (bus_wstrb),
        .ready_o  (systick_ready),
        .rdata_o  (systick_rdata),
        .irq_o    (irq_o[0])
    );

    gpio #(
        .WIDTH (GPIO_WIDTH)
    ) i_gpio (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .sel_i     (gpio_sel),
        .addr_i    (bus_addr[4:0]),
        .wdata_i   (bus_wdata),
        .wstrb_i   (bus_wstrb),
        .ready_o   (gpio_ready),
        .rdata_o   (gpio_rdata),
        .irq_o     (irq_o[1]),
        .pins_i    (gpio_i),
        .pins_o    (gpio_o),
        .pins_oe_o (gpio_oe_o)
    );

endmodule

`default_nettype wire

// File: verification/periph_subsys_props.sv
`timescale 1ns/10ps
`default_nettype none

module periph_subsys_props (
    input wire logic clk_i,
    input wire logic arst_n_i,
    input wire logic mem_valid_i,
    input wire logic mem_ready_i,
    input wire logic sram_sel_i,
    input wire logic systick_sel_i,
    input wire logic gpio_sel_i,
    input wire logic sram_ready_i,
    input wire logic systick_ready_i,
    input wire logic gpio_ready_i,
    input wire logic unmapped_ready_i
);

    // The windows never overlap
    a_sel_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $onehot0({sram_sel_i, systick_sel_i, gpio_sel_i}))
        else $error("More than one slave select is high");

    // Each pulse lands while the master still holds its request
    a_ready_needs_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (sram_ready_i | systick_ready_i | gpio_ready_i | unmapped_ready_i) |-> mem_valid_i)
        else $error("A slave raised ready without valid");

    a_fixed_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $rose(mem_valid_i) |=> mem_ready_i)
        else $error("Ready did not follow valid after one cycle");

endmodule

bind bus_interconnect periph_subsys_props i_props (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .mem_valid_i      (mem_valid_i),
    .mem_ready_i      (mem_ready_o),
    .sram_sel_i       (sram_sel_o),
    .systick_sel_i    (systick_sel_o),
    .gpio_sel_i       (gpio_sel_o),
    .sram_ready_i     (sram_ready_i),
    .systick_ready_i  (systick_ready_i),
    .gpio_ready_i     (gpio_ready_i),
    .unmapped_ready_i (unmapped_ready_q)
);

`default_nettype wire

// File: verification/tb_periph_subsys.sv
`timescale 1ns/10ps
`default_nettype none

module tb_periph_subsys;

    localparam int unsigned SRAM_ADDR_WIDTH = 13;
    localparam int unsigned GPIO_WIDTH      = 8;
    localparam int unsigned SRAM_WORDS      = 2 ** (SRAM_ADDR_WIDTH - 2);
    localparam int unsigned VEC_WORDS       = 5 * 64;
    localparam int          BUS_TIMEOUT     = 16;
    localparam int          SRAM_ACCESSES   = 40;

    logic                           clk_i;
    logic                           arst_n_i;
    logic                           mem_valid_i;
    logic [soc_pkg::ADDR_WIDTH-1:0] mem_addr_i;
    logic [soc_pkg::DATA_WIDTH-1:0] mem_wdata_i;
    logic [soc_pkg::STRB_WIDTH-1:0] mem_wstrb_i;
    logic                           mem_ready_o;
    logic [soc_pkg::DATA_WIDTH-1:0] mem_rdata_o;
    logic [1:0]                     irq_o;
    logic [GPIO_WIDTH-1:0]          gpio_i;
    logic [GPIO_WIDTH-1:0]          gpio_o;
    logic [GPIO_WIDTH-1:0]          gpio_oe_o;
    logic [GPIO_WIDTH-1:0]          pin_drive;
    int unsigned                    seed_init;

    logic [31:0] vec_mem [0:VEC_WORDS-1];
    logic [31:0] sram_model [0:SRAM_WORDS-1];
    logic        model_valid [0:SRAM_WORDS-1];
    int          touched [$];

    assign gpio_i = (gpio_o & gpio_oe_o) | (pin_drive & ~gpio_oe_o); // Output pins loop back

    periph_subsys #(
        .SRAM_ADDR_WIDTH (SRAM_ADDR_WIDTH),
        .GPIO_WIDTH      (GPIO_WIDTH)
    ) i_dut (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .mem_valid_i (mem_valid_i),
        .mem_addr_i  (mem_addr_i),
        .mem_wdata_i (mem_wdata_i),
        .mem_wstrb_i (mem_wstrb_i),
        .mem_ready_o (mem_ready_o),
        .mem_rdata_o (mem_rdata_o),
        .irq_o       (irq_o),
        .gpio_i      (gpio_i),
        .gpio_o      (gpio_o),
        .gpio_oe_o   (gpio_oe_o)
    );

    initial clk_i = 1'b0;
    always #50 clk_i = ~clk_i;

    task automatic report_failure();
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error: %s is %h, expected %h", name, actual, expected);
            report_failure();
        end
    endtask

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  strb);
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    // Ready must come in the cycle after valid rises
    task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] strb, output logic [31:0] rdata);
        int   lat;
        logic seen;
        lat   = 0;
        seen  = 1'b0;
        rdata = '0;
        @(posedge clk_i);
        #1;
        mem_valid_i = 1'b1;
        mem_addr_i  = addr;
        mem_wdata_i = wdata;
        mem_wstrb_i = strb;
        while (!seen && lat < BUS_TIMEOUT) begin
            @(posedge clk_i);
            if (mem_ready_o) begin
                seen  = 1'b1;
                rdata = mem_rdata_o;
            end else begin
                lat++;
            end
        end
        if (!seen) begin
            $display("The slave at address %h never answered within %0d cycles", addr, lat);
            report_failure();
        end
        check_value("mem_ready_o latency", lat, 1);
        #1;
        mem_valid_i = 1'b0;
        mem_wstrb_i = '0;
    endtask

    task automatic poll_reg(input logic [31:0] addr, input logic [31:0] expected,
                            input logic [31:0] mask, input int limit);
        logic [31:0] rdata;
        int          tries;
        logic        hit;
        tries = 0;
        hit   = 1'b0;
        while (!hit && tries < limit) begin
            bus_access(addr, 32'h0, 4'h0, rdata);
            hit = ((rdata & mask) == (expected & mask));
            tries++;
        end
        if (!hit) begin
            $display("Register %h did not reach %h under mask %h within %0d reads",
                     addr, expected, mask, limit);
            report_failure();
        end
    endtask

    task automatic sram_random(input int count);
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] rdata;
        logic [3:0]  strb;
        int          idx;
        int          n;
        for (n = 0; n < count; n++) begin
            idx  = $urandom_range(SRAM_WORDS - 1, 0);
            addr = soc_pkg::SRAM_BASE + (idx << 2);
            if (!model_valid[idx]) begin
                data = $urandom;
                bus_access(addr, data, 4'hf, rdata); // Contents start unknown so the word is filled
                sram_model[idx]  = data;
                model_valid[idx] = 1'b1;
                touched.push_back(idx);
            end
            data = $urandom;
            strb = $urandom_range(15, 1);
            bus_access(addr, data, strb, rdata);
            sram_model[idx] = merge_bytes(sram_model[idx], data, strb);
            bus_access(addr, 32'h0, 4'h0, rdata);
            check_value($sformatf("sram word at %h", addr), rdata, sram_model[idx]);
        end
    endtask

    task automatic sram_readback();
        logic [31:0] addr;
        logic [31:0] rdata;
        int          n;
        for (n = 0; n < touched.size(); n++) begin
            addr = soc_pkg::SRAM_BASE + (touched[n] << 2);
            bus_access(addr, 32'h0, 4'h0, rdata);
            check_value($sformatf("sram word at %h", addr), rdata, sram_model[touched[n]]);
        end
    endtask

    task automatic run_vectors();
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] mask;
        logic [31:0] limit;
        logic [31:0] rdata;
        int          v;
        v  = 0;
        op = vec_mem[0];
        while (op !== 32'd0) begin
            if ($isunknown(op) || v >= VEC_WORDS / 5 - 1) begin
                $display("The vector file has no end marker or a malformed line at entry %0d", v);
                report_failure();
            end
            addr  = vec_mem[5*v+1];
            data  = vec_mem[5*v+2];
            mask  = vec_mem[5*v+3];
            limit = vec_mem[5*v+4];
            case (op)
                1: bus_access(addr, data, mask[3:0], rdata);
                2: begin
                    bus_access(addr, 32'h0, 4'h0, rdata);
                    check_value($sformatf("mem_rdata_o at %h", addr), rdata & mask, data & mask);
                end
                3: poll_reg(addr, data, mask, limit);
                4: begin
                    @(posedge clk_i);
                    #1;
                    pin_drive = data[GPIO_WIDTH-1:0];
                end
                5: check_value("irq_o", {30'd0, irq_o}, data);
                6: begin
                    check_value("gpio_o", {24'd0, gpio_o}, data);
                    check_value("gpio_oe_o", {24'd0, gpio_oe_o}, mask);
                end
                default: begin
                    $display("Unknown opcode %0h in vector %0d", op, v);
                    report_failure();
                end
            endcase
            v++;
            op = vec_mem[5*v];
        end
    endtask

    initial begin
        seed_init   = $urandom(32);
        arst_n_i    = 1'b0;
        mem_valid_i = 1'b0;
        mem_addr_i  = '0;
        mem_wdata_i = '0;
        mem_wstrb_i = '0;
        pin_drive   = '0;
        for (int w = 0; w < SRAM_WORDS; w++) begin
            model_valid[w] = 1'b0;
        end
        $readmemh("verification/periph_vectors.txt", vec_mem);
        repeat (8) @(posedge clk_i);
        #1;
        arst_n_i = 1'b1;
        check_value("mem_ready_o", {31'd0, mem_ready_o}, 32'd0);
        check_value("irq_o", {30'd0, irq_o}, 32'd0);
        check_value("gpio_o", {24'd0, gpio_o}, 32'd0);
        check_value("gpio_oe_o", {24'd0, gpio_oe_o}, 32'd0);
        sram_random(SRAM_ACCESSES);
        sram_readback();
        run_vectors();
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/periph_vectors.txt
// Columns, all hex: op addr data mask limit
// op 1 write (mask is strobes), 2 read, 3 poll (limit is reads), 4 drive pins with data,
// op 5 expect irq_o equal to data, 6 expect gpio_o equal to data and gpio_oe_o to mask, 0 end
1 00020000 11223344 0000000f 0
1 00020000 aabbccdd 00000005 0
2 00020000 11bb33dd ffffffff 0
1 00021ffc cafef00d 0000000f 0
2 00021ffc cafef00d ffffffff 0
2 00040000 00000000 ffffffff 0
2 80000500 00000000 ffffffff 0
2 80000110 00000000 ffffffff 0
1 80000104 00000005 0000000f 0
1 80000100 00000003 0000000f 0
3 8000010c 00000001 00000001 14
5 00000000 00000001 00000000 0
1 80000100 00000002 0000000f 0
2 80000100 00000002 ffffffff 0
2 80000104 00000005 ffffffff 0
5 00000000 00000001 00000000 0
1 8000010c 00000001 0000000f 0
2 8000010c 00000000 00000001 0
5 00000000 00000000 00000000 0
1 80000404 0000000f 0000000f 0
1 80000400 00000005 0000000f 0
6 00000000 00000005 0000000f 0
2 80000400 00000005 ffffffff 0
2 80000404 0000000f ffffffff 0
4 00000000 000000a0 00000000 0
3 80000408 000000a5 ffffffff 10
1 8000040c 00000010 0000000f 0
4 00000000 000000b0 00000000 0
3 80000410 00000010 000000ff 10
5 00000000 00000002 00000000 0
4 00000000 000000f0 00000000 0
3 80000408 000000f5 ffffffff 10
2 80000410 00000010 ffffffff 0
1 80000410 00000010 0000000f 0
2 80000410 00000000 ffffffff 0
5 00000000 00000000 00000000 0
0 00000000 00000000 00000000 0

// File: vlog.f
verilog/soc_pkg.sv
verilog/sram.sv
verilog/systick.sv
verilog/gpio.sv
verilog/bus_interconnect.sv
verilog/periph_subsys.sv
verification/periph_subsys_props.sv
verification/tb_periph_subsys.sv

// File: Bender.yml
package:
  name: periph_subsys

sources:
  - files:
      - verilog/soc_pkg.sv
      - verilog/sram.sv
      - verilog/systick.sv
      - verilog/gpio.sv
      - verilog/bus_interconnect.sv
      - verilog/periph_subsys.sv
  - target: test
    files:
      - verification/periph_subsys_props.sv
      - verification/tb_periph_subsys.sv
